// ==== Makefile ====
# Verilator build and run for the USB OUT/SETUP protocol engine

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := usb_out_pe_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, the simulator exit code is hidden by tee
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG); then \
	  echo "simulation reported a failure"; \
	  exit 1; \
	fi
	@grep -q "test passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== src.f ====
+incdir+tests
verilog/usb_out_pkg.sv
verilog/usb_out_tok_if.sv
verilog/usb_token_decode.sv
verilog/usb_out_ep_slice.sv
verilog/usb_out_xact_fsm.sv
verilog/usb_out_pe.sv
tests/usb_out_pe_tb.sv

// ==== tests/usb_host_model.svh ====
/*
 * USB host model for the OUT engine testbench
 * Token and data packet drivers and the expected handshake rule
 */
`ifndef USB_HOST_MODEL_SVH
`define USB_HOST_MODEL_SVH

  // Expected outcome of one transaction
  typedef struct packed {
    logic       send;
    logic [3:0] pid;
    logic       acked;
    logic       rollback;
    logic [1:0] delay_cyc;
  } reply_t;

  ////////////////////
  // Packet drivers
  ////////////////////

  // Token packet end with PID, address and endpoint
  task automatic send_token(input logic [3:0] pid, input logic [6:0] addr,
                            input logic [3:0] endp);
    @(posedge clk_48mhz);
    rx_pkt_end   <= 1'b1;
    rx_pkt_valid <= 1'b1;
    rx_pid       <= pid;
    rx_addr      <= addr;
    rx_endp      <= endp;
    @(posedge clk_48mhz);
    rx_pkt_end   <= 1'b0;
    rx_pkt_valid <= 1'b0;
  endtask

  // DATA0/DATA1 packet of random bytes; keep means the engine should take them
  task automatic send_data(input logic tog, input int nbytes, input logic crc_ok,
                           input logic keep);
    logic [7:0] b;
    @(posedge clk_48mhz);
    rx_pkt_start <= 1'b1;
    @(posedge clk_48mhz);
    rx_pkt_start <= 1'b0;
    for (int i = 0; i < nbytes; i++) begin
      b = 8'($random(seed));
      if (keep) begin
        byte_q.push_back(b);
      end
      rx_data_put <= 1'b1;
      rx_data     <= b;
      @(posedge clk_48mhz);
    end
    rx_data_put <= 1'b0;
    @(posedge clk_48mhz);
    // Packet end carries the data PID and the CRC result
    rx_pkt_end   <= 1'b1;
    rx_pkt_valid <= crc_ok;
    rx_pid       <= tog ? UsbPidData1 : UsbPidData0;
    @(posedge clk_48mhz);
    rx_pkt_end   <= 1'b0;
    rx_pkt_valid <= 1'b0;
  endtask

  // Packet length of 1 to 32 bytes
  function automatic int rand_len();
    return 1 + int'($unsigned($random(seed)) % MaxOutPktSizeByte);
  endfunction

  ////////////////////
  // Reference rule
  ////////////////////

  function automatic reply_t expected_reply(input logic is_setup, input logic is_control,
                                            input logic stall, input logic full,
                                            input logic tog_ok);
    reply_t r;
    r = '0;
    r.delay_cyc = 2'd1;
    if (is_setup && !is_control) begin
      // Token not taken, no transaction at all
      r.delay_cyc = 2'd0;
    end else if (!tog_ok && !stall) begin
      // Host lost our ACK, ACK again at once and drop the copy
      r.send      = 1'b1;
      r.pid       = UsbPidAck;
      r.rollback  = 1'b1;
      r.delay_cyc = 2'd0;
    end else if (is_setup) begin
      // SETUP is taken or dropped without a reply
      if (full) begin
        r.rollback = 1'b1;
      end else begin
        r.send  = 1'b1;
        r.pid   = UsbPidAck;
        r.acked = 1'b1;
      end
    end else if (stall) begin
      r.send = 1'b1;
      r.pid  = UsbPidStall;
    end else if (full) begin
      r.send     = 1'b1;
      r.pid      = UsbPidNak;
      r.rollback = 1'b1;
    end else begin
      r.send  = 1'b1;
      r.pid   = UsbPidAck;
      r.acked = 1'b1;
    end
    return r;
  endfunction

`endif

// ==== tests/usb_out_pe_tb.sv ====
/*
 * Testbench for the USB OUT/SETUP protocol engine
 * Host model drives packets, a monitor checks replies, puts and toggles
 */
`timescale 1ns/1ps

module usb_out_pe_tb;
  import usb_out_pkg::*;

  // About 20 transactions of at most 45 cycles, an 80 cycle wait and reset,
  // with wide margin
  localparam int MaxCycles = 4000;
  localparam logic [6:0] DevAddr = 7'h2a;

  logic            clk_48mhz = 1'b0;
  logic            rst_n;
  logic            link_reset;
  logic [6:0]      dev_addr;
  ep_vec_t         cfg_enabled;
  ep_vec_t         cfg_control;
  ep_vec_t         cfg_full;
  ep_vec_t         cfg_stall;
  logic            rx_pkt_start;
  logic            rx_pkt_end;
  logic            rx_pkt_valid;
  logic [3:0]      rx_pid;
  logic [6:0]      rx_addr;
  logic [3:0]      rx_endp;
  logic            rx_data_put;
  logic [7:0]      rx_data;
  logic            tx_pkt_start;
  logic [3:0]      tx_pid;
  logic [3:0]      ep_current;
  logic            newpkt;
  logic            data_put;
  logic [PktW-1:0] put_addr;
  logic [7:0]      data;
  logic            acked;
  logic            rollback;
  ep_vec_t         setup_flags;
  ep_vec_t         toggles;

  integer          seed;
  int              cyc = 0;
  int              mon_cyc = 0;
  int              last_end_cyc = 0;
  int              err_cnt = 0;
  int              outcome_cnt = 0;
  int              newpkt_cnt = 0;
  logic [7:0]      byte_q[$];

  `include "usb_host_model.svh"

  // Expected state of the transaction in flight
  reply_t          exp_reply;
  logic            exp_valid;
  logic            exp_newpkt;
  logic [3:0]      exp_ep;
  logic [PktW-1:0] exp_addr;
  logic            nak_pend;
  ep_vec_t         ref_tog;
  ep_vec_t         ref_setup;

  always #5 clk_48mhz = ~clk_48mhz;

  usb_out_pe usb_out_pe_i (
    .clk_48mhz_i       (clk_48mhz),
    .rst_ni            (rst_n),
    .link_reset_i      (link_reset),
    .dev_addr_i        (dev_addr),
    .out_ep_enabled_i  (cfg_enabled),
    .out_ep_control_i  (cfg_control),
    .out_ep_full_i     (cfg_full),
    .out_ep_stall_i    (cfg_stall),
    .rx_pkt_start_i    (rx_pkt_start),
    .rx_pkt_end_i      (rx_pkt_end),
    .rx_pkt_valid_i    (rx_pkt_valid),
    .rx_pid_i          (rx_pid),
    .rx_addr_i         (rx_addr),
    .rx_endp_i         (rx_endp),
    .rx_data_put_i     (rx_data_put),
    .rx_data_i         (rx_data),
    .tx_pkt_start_o    (tx_pkt_start),
    .tx_pid_o          (tx_pid),
    .out_ep_current_o  (ep_current),
    .out_ep_newpkt_o   (newpkt),
    .out_ep_data_put_o (data_put),
    .out_ep_put_addr_o (put_addr),
    .out_ep_data_o     (data),
    .out_ep_acked_o    (acked),
    .out_ep_rollback_o (rollback),
    .out_ep_setup_o    (setup_flags),
    .out_data_toggle_o (toggles)
  );

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("test failed");
      $fatal(1);
    end
  endtask

  task automatic fail_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  always @(posedge clk_48mhz) begin
    cyc <= cyc + 1;
    if (cyc >= MaxCycles) begin
      fail_run("Run did not finish within the cycle limit");
    end
  end

  // Monitor of newpkt, puts and the reply of each transaction
  always @(negedge clk_48mhz) begin
    if (rst_n) begin
      mon_cyc++;
      if (rx_pkt_end) begin
        last_end_cyc = mon_cyc;
      end
      if (newpkt) begin
        if (!exp_newpkt) begin
          fail_run("newpkt strobe without an accepted token");
        end
        check_equal(mon_cyc - last_end_cyc, 1, "newpkt delay");
        check_equal(ep_current, exp_ep, "current endpoint");
        exp_newpkt = 1'b0;
        newpkt_cnt++;
        exp_addr   = '0;
        nak_pend   = 1'b0;
      end
      if (data_put) begin
        if (byte_q.size() == 0) begin
          fail_run("Data put with no received byte left to put");
        end
        check_equal(put_addr, exp_addr, "put address");
        check_equal(data, byte_q.pop_front(), "put data");
        // Address holds once a NAK is pending or at the last slot
        if (!nak_pend && (exp_addr != PktW'(MaxOutPktSizeByte - 1))) begin
          exp_addr++;
        end
        if (cfg_full[exp_ep]) begin
          nak_pend = 1'b1;
        end
      end
      if (tx_pkt_start || acked || rollback) begin
        if (!exp_valid) begin
          fail_run("Reply or buffer strobe while no transaction expects one");
        end
        check_equal(tx_pkt_start, exp_reply.send, "tx_pkt_start");
        if (exp_reply.send) begin
          check_equal(tx_pid, exp_reply.pid, "tx_pid");
        end
        check_equal(acked, exp_reply.acked, "acked");
        check_equal(rollback, exp_reply.rollback, "rollback");
        check_equal(mon_cyc - last_end_cyc, exp_reply.delay_cyc, "reply delay");
        exp_valid = 1'b0;
        outcome_cnt++;
      end
    end
  end

  ////////////////////
  // Test steps
  ////////////////////

  task automatic set_cfg(input ep_vec_t full, input ep_vec_t stall);
    @(posedge clk_48mhz);
    cfg_full  <= full;
    cfg_stall <= stall;
    @(posedge clk_48mhz);
  endtask

  // One token plus data packet, checked against the reference rule
  task automatic do_xact(input logic is_setup, input int ep, input int nbytes,
                         input logic tog, input logic crc_ok);
    reply_t r;
    logic   accepted;
    int     start_cnt;
    int     pkt_before;
    accepted = cfg_enabled[ep] && (!is_setup || cfg_control[ep]);
    // Slices track token type even when SETUP is refused
    if (cfg_enabled[ep]) begin
      ref_setup[ep] = is_setup;
      if (is_setup) begin
        ref_tog[ep] = 1'b0;
      end
    end
    r = expected_reply(is_setup, cfg_control[ep], cfg_stall[ep], cfg_full[ep],
                       tog == ref_tog[ep]);
    if (accepted && !crc_ok) begin
      r = '0;
      r.rollback = 1'b1;
    end
    exp_reply  = r;
    exp_valid  = accepted;
    exp_newpkt = accepted;
    exp_ep     = 4'(ep);
    start_cnt  = outcome_cnt;
    pkt_before = newpkt_cnt;
    send_token(is_setup ? UsbPidSetup : UsbPidOut, DevAddr, 4'(ep));
    send_data(tog, nbytes, crc_ok, accepted);
    if (accepted) begin
      while (outcome_cnt == start_cnt) begin
        @(negedge clk_48mhz);
      end
    end else begin
      repeat (10) @(negedge clk_48mhz);
    end
    repeat (2) @(negedge clk_48mhz);
    if (r.acked) begin
      ref_tog[ep] = ~ref_tog[ep];
    end
    check_equal(newpkt_cnt - pkt_before, accepted, "newpkt count");
    check_equal(byte_q.size(), 0, "bytes never put");
    check_equal(toggles, ref_tog, "data toggles");
    check_equal(setup_flags, ref_setup, "setup flags");
  endtask

  // Monitor flags any newpkt while this token is on the bus
  task automatic ignored_token(input logic [6:0] addr, input logic [3:0] endp);
    exp_valid  = 1'b0;
    exp_newpkt = 1'b0;
    send_token(UsbPidOut, addr, endp);
    repeat (10) @(negedge clk_48mhz);
  endtask

  initial begin
    int pkt_before;
    seed         = 32'h5812;
    rst_n        = 1'b0;
    link_reset   = 1'b0;
    dev_addr     = DevAddr;
    // Endpoint 3 off, endpoint 0 is the control endpoint
    cfg_enabled  = 4'b0111;
    cfg_control  = 4'b0001;
    cfg_full     = '0;
    cfg_stall    = '0;
    rx_pkt_start = 1'b0;
    rx_pkt_end   = 1'b0;
    rx_pkt_valid = 1'b0;
    rx_pid       = 4'b0000;
    rx_addr      = '0;
    rx_endp      = '0;
    rx_data_put  = 1'b0;
    rx_data      = '0;
    exp_reply    = '0;
    exp_valid    = 1'b0;
    exp_newpkt   = 1'b0;
    exp_ep       = '0;
    exp_addr     = '0;
    nak_pend     = 1'b0;
    ref_tog      = '0;
    ref_setup    = '0;
    repeat (10) @(posedge clk_48mhz);
    rst_n <= 1'b1;
    repeat (2) @(negedge clk_48mhz);
    check_equal(toggles, 0, "toggles after reset");
    check_equal(setup_flags, 0, "setup flags after reset");

    // OUT with the right toggle, one packet at full size
    for (int i = 0; i < 3; i++) begin
      do_xact(1'b0, 1, rand_len(), ref_tog[1], 1'b1);
    end
    do_xact(1'b0, 2, 32, ref_tog[2], 1'b1);
    do_xact(1'b0, 0, rand_len(), ref_tog[0], 1'b1);

    // Stale toggle, then a packet with bad CRC
    do_xact(1'b0, 1, rand_len(), ~ref_tog[1], 1'b1);
    do_xact(1'b0, 2, rand_len(), ref_tog[2], 1'b0);

    // Full endpoint NAKs, stalled endpoint STALLs
    set_cfg(4'b0100, 4'b0000);
    do_xact(1'b0, 2, 6, ref_tog[2], 1'b1);
    set_cfg(4'b0000, 4'b0010);
    do_xact(1'b0, 1, rand_len(), ref_tog[1], 1'b1);
    set_cfg(4'b0000, 4'b0000);

    // Link reset returns every toggle to DATA0
    @(posedge clk_48mhz);
    link_reset <= 1'b1;
    @(posedge clk_48mhz);
    link_reset <= 1'b0;
    repeat (2) @(negedge clk_48mhz);
    ref_tog = '0;
    check_equal(toggles, ref_tog, "toggles after link reset");
    check_equal(setup_flags, ref_setup, "setup flags after link reset");

    // SETUP on the control endpoint, then an OUT clears the flag
    do_xact(1'b1, 0, 8, 1'b0, 1'b1);
    do_xact(1'b0, 0, rand_len(), ref_tog[0], 1'b1);
    // Non-control endpoint refuses SETUP
    do_xact(1'b1, 1, 8, 1'b0, 1'b1);
    // Full control endpoint drops SETUP silently
    set_cfg(4'b0001, 4'b0000);
    do_xact(1'b1, 0, 8, 1'b0, 1'b1);
    set_cfg(4'b0000, 4'b0000);

    // Wrong address, endpoint past the last slice, disabled endpoint
    ignored_token(DevAddr ^ 7'h01, 4'd1);
    ignored_token(DevAddr, 4'd5);
    ignored_token(DevAddr, 4'd3);

    // Token with no data packet
    pkt_before = newpkt_cnt;
    exp_valid  = 1'b0;
    exp_newpkt = 1'b1;
    exp_ep     = 4'd2;
    send_token(UsbPidOut, DevAddr, 4'd2);
    repeat (80) @(negedge clk_48mhz);
    check_equal(newpkt_cnt - pkt_before, 1, "newpkt before timeout");
    check_equal(toggles, ref_tog, "toggles after timeout");
    do_xact(1'b0, 2, rand_len(), ref_tog[2], 1'b1);

    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== verilog/usb_out_ep_slice.sv ====
/*
 * OUT endpoint slice
 * Data toggle, setup flag and start request of one endpoint
 */
`timescale 1ns/1ps

module usb_out_ep_slice #(
  parameter int unsigned EpIdx = 0
) (
  input  logic                           clk_48mhz_i,
  input  logic                           rst_ni,
  input  logic                           link_reset_i,
  input  logic                           enabled_i,
  input  logic                           control_i,
  usb_out_tok_if.slice                   tok,
  input  logic [usb_out_pkg::OutEpW-1:0] cur_ep_i,
  input  logic                           adv_tog_i,
  output logic                           start_o,
  output logic                           toggle_o,
  output logic                           setup_o
);
  import usb_out_pkg::*;

  localparam logic [OutEpW-1:0] MyEp = OutEpW'(EpIdx);

  logic sel;
  logic setup_hit;
  logic out_hit;

  // Token names this endpoint and the endpoint is on
  assign sel = (tok.tok_ep == MyEp) && enabled_i;

  assign setup_hit = sel && tok.tok_setup;
  assign out_hit   = sel && tok.tok_out;

  // SETUP is only taken by a control endpoint
  assign start_o = out_hit || (setup_hit && control_i);

  // Setup flag follows the last token type
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setup_o <= 1'b0;
    end else if (setup_hit) begin
      setup_o <= 1'b1;
    end else if (out_hit) begin
      setup_o <= 1'b0;
    end
  end

  // SETUP always restarts the sequence at DATA0
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      toggle_o <= 1'b0;
    end else if (link_reset_i) begin
      toggle_o <= 1'b0;
    end else if (setup_hit) begin
      toggle_o <= 1'b0;
    end else if (adv_tog_i && (cur_ep_i == MyEp)) begin
      // Engine has ACKed a new packet here
      toggle_o <= ~toggle_o;
    end
  end

endmodule

// ==== verilog/usb_out_pe.sv ====
/*
 * USB full-speed OUT/SETUP protocol engine without packet buffers
 * Decoder, one slice per endpoint and the transaction engine
 */
`timescale 1ns/1ps

module usb_out_pe (
  input  logic                           clk_48mhz_i,
  input  logic                           rst_ni,
  input  logic                           link_reset_i,
  input  logic [6:0]                     dev_addr_i,

  // Endpoint configuration
  input  usb_out_pkg::ep_vec_t           out_ep_enabled_i,
  input  usb_out_pkg::ep_vec_t           out_ep_control_i,
  input  usb_out_pkg::ep_vec_t           out_ep_full_i,
  input  usb_out_pkg::ep_vec_t           out_ep_stall_i,

  // Receive side
  input  logic                           rx_pkt_start_i,
  input  logic                           rx_pkt_end_i,
  input  logic                           rx_pkt_valid_i,
  input  logic [3:0]                     rx_pid_i,
  input  logic [6:0]                     rx_addr_i,
  input  logic [3:0]                     rx_endp_i,
  input  logic                           rx_data_put_i,
  input  logic [7:0]                     rx_data_i,

  // Transmit side
  output logic                           tx_pkt_start_o,
  output logic [3:0]                     tx_pid_o,

  // Buffer side
  output logic [3:0]                     out_ep_current_o,
  output logic                           out_ep_newpkt_o,
  output logic                           out_ep_data_put_o,
  output logic [usb_out_pkg::PktW-1:0]   out_ep_put_addr_o,
  output logic [7:0]                     out_ep_data_o,
  output logic                           out_ep_acked_o,
  output logic                           out_ep_rollback_o,
  output usb_out_pkg::ep_vec_t           out_ep_setup_o,
  output usb_out_pkg::ep_vec_t           out_data_toggle_o
);
  import usb_out_pkg::*;

  ep_vec_t           ep_start;
  logic [OutEpW-1:0] cur_ep;
  logic              adv_tog;

  usb_out_tok_if tok_if ();

  usb_token_decode u_decode (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .dev_addr_i     (dev_addr_i),
    .rx_pkt_end_i   (rx_pkt_end_i),
    .rx_pkt_valid_i (rx_pkt_valid_i),
    .rx_pid_i       (rx_pid_i),
    .rx_addr_i      (rx_addr_i),
    .rx_endp_i      (rx_endp_i),
    .tok            (tok_if.decoder)
  );

  ////////////////////
  // Endpoint slices
  ////////////////////

  for (genvar i = 0; i < NumOutEps; i++) begin : g_ep
    usb_out_ep_slice #(
      .EpIdx (i)
    ) u_slice (
      .clk_48mhz_i  (clk_48mhz_i),
      .rst_ni       (rst_ni),
      .link_reset_i (link_reset_i),
      .enabled_i    (out_ep_enabled_i[i]),
      .control_i    (out_ep_control_i[i]),
      .tok          (tok_if.slice),
      .cur_ep_i     (cur_ep),
      .adv_tog_i    (adv_tog),
      .start_o      (ep_start[i]),
      .toggle_o     (out_data_toggle_o[i]),
      .setup_o      (out_ep_setup_o[i])
    );
  end

  usb_out_xact_fsm u_xact (
    .clk_48mhz_i    (clk_48mhz_i),
    .rst_ni         (rst_ni),
    .link_reset_i   (link_reset_i),
    .tok            (tok_if.engine),
    .start_i        (ep_start),
    .toggle_i       (out_data_toggle_o),
    .full_i         (out_ep_full_i),
    .stall_i        (out_ep_stall_i),
    .rx_pkt_start_i (rx_pkt_start_i),
    .rx_data_put_i  (rx_data_put_i),
    .rx_data_i      (rx_data_i),
    .cur_ep_o       (cur_ep),
    .adv_tog_o      (adv_tog),
    .ep_current_o   (out_ep_current_o),
    .newpkt_o       (out_ep_newpkt_o),
    .data_put_o     (out_ep_data_put_o),
    .put_addr_o     (out_ep_put_addr_o),
    .data_o         (out_ep_data_o),
    .acked_o        (out_ep_acked_o),
    .rollback_o     (out_ep_rollback_o),
    .tx_pkt_start_o (tx_pkt_start_o),
    .tx_pid_o       (tx_pid_o)
  );

endmodule

// ==== verilog/usb_out_pkg.sv ====
/*
 * USB full-speed OUT engine definitions
 * PID codes, PID field view, endpoint count, packet size and timeout
 */
package usb_out_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Implemented OUT endpoints
  localparam int unsigned NumOutEps = 4;
  localparam int unsigned OutEpW = 2;

  // Largest packet the buffer side accepts
  localparam int unsigned MaxOutPktSizeByte = 32;
  localparam int unsigned PktW = 5;

  // 17 bit times at 4 clocks per bit on the 48 MHz clock
  localparam int unsigned AckTimeoutCnt = 68;
  localparam int unsigned AckTimeoutCntW = 7;

  ////////////////////
  // PID encoding
  ////////////////////

  // Low nibble of the PID byte as sent on the bus
  typedef enum logic [3:0] {
    UsbPidOut   = 4'b0001,
    UsbPidIn    = 4'b1001,
    UsbPidSetup = 4'b1101,
    UsbPidData0 = 4'b0011,
    UsbPidData1 = 4'b1011,
    UsbPidAck   = 4'b0010,
    UsbPidNak   = 4'b1010,
    UsbPidStall = 4'b1110
  } usb_pid_e;

  // Packet class in the two low PID bits
  typedef enum logic [1:0] {
    UsbPidTypeSpecial   = 2'b00,
    UsbPidTypeToken     = 2'b01,
    UsbPidTypeHandshake = 2'b10,
    UsbPidTypeData      = 2'b11
  } usb_pid_type_e;

  // Field view of the same nibble
  typedef struct packed {
    logic          tog;
    logic          sub;
    usb_pid_type_e pid_type;
  } usb_pid_fields_t;

  // One received PID read as a code or as fields
  typedef union packed {
    usb_pid_e        pid;
    usb_pid_fields_t f;
  } usb_pid_u;

  // One bit per endpoint
  typedef logic [NumOutEps-1:0] ep_vec_t;

endpackage

// ==== verilog/usb_out_tok_if.sv ====
/*
 * Decoded bus events
 * Token, data-end and bad-packet strobes from the decoder
 */
`timescale 1ns/1ps

interface usb_out_tok_if;
  import usb_out_pkg::*;

  // Token strobes, already matched to address and implemented endpoint
  logic              tok_out;
  logic              tok_setup;
  logic [OutEpW-1:0] tok_ep;

  // End of a good DATA0 or DATA1 packet and its toggle
  logic              data_end;
  logic              data_tog;

  // End of a corrupt packet or of a good non-data packet
  logic              bad_end;

  modport decoder (
    output tok_out, tok_setup, tok_ep,
    output data_end, data_tog, bad_end
  );

  // Endpoint slices only look at tokens
  modport slice (
    input tok_out, tok_setup, tok_ep
  );

  modport engine (
    input tok_out, tok_setup, tok_ep,
    input data_end, data_tog, bad_end
  );

endinterface

// ==== verilog/usb_out_xact_fsm.sv ====
/*
 * OUT transaction engine
 * Waits for host data, streams bytes out and picks the handshake
 */
`timescale 1ns/1ps

module usb_out_xact_fsm (
  input  logic                           clk_48mhz_i,
  input  logic                           rst_ni,
  input  logic                           link_reset_i,
  usb_out_tok_if.engine                  tok,
  input  usb_out_pkg::ep_vec_t           start_i,
  input  usb_out_pkg::ep_vec_t           toggle_i,
  input  usb_out_pkg::ep_vec_t           full_i,
  input  usb_out_pkg::ep_vec_t           stall_i,
  input  logic                           rx_pkt_start_i,
  input  logic                           rx_data_put_i,
  input  logic [7:0]                     rx_data_i,
  output logic [usb_out_pkg::OutEpW-1:0] cur_ep_o,
  output logic                           adv_tog_o,
  output logic [3:0]                     ep_current_o,
  output logic                           newpkt_o,
  output logic                           data_put_o,
  output logic [usb_out_pkg::PktW-1:0]   put_addr_o,
  output logic [7:0]                     data_o,
  output logic                           acked_o,
  output logic                           rollback_o,
  output logic                           tx_pkt_start_o,
  output logic [3:0]                     tx_pid_o
);
  import usb_out_pkg::*;

  typedef enum logic [1:0] {
    StIdle,
    StWaitData,
    StInData,
    StDataEnd
  } state_e;

  localparam logic [PktW-1:0] LastAddr = PktW'(MaxOutPktSizeByte - 1);

  state_e                    state_q;
  state_e                    state_d;
  logic                      xact_start;
  logic                      setup_q;
  logic                      nak_q;
  logic [AckTimeoutCntW-1:0] timeout_q;
  logic [AckTimeoutCntW-1:0] timeout_d;
  logic                      ep_full;
  logic                      ep_stall;
  logic                      bad_tog;
  logic                      inc_addr;

  // Per-endpoint inputs of the current transaction
  assign ep_full  = full_i[cur_ep_o];
  assign ep_stall = stall_i[cur_ep_o];

  // Host resent a packet we already took
  assign bad_tog = tok.data_end && (tok.data_tog != toggle_i[cur_ep_o]);

  assign ep_current_o = {{(4 - OutEpW){1'b0}}, cur_ep_o};

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d        = state_q;
    xact_start     = 1'b0;
    timeout_d      = AckTimeoutCntW'(AckTimeoutCnt);
    tx_pkt_start_o = 1'b0;
    tx_pid_o       = 4'b0000;
    acked_o        = 1'b0;
    rollback_o     = 1'b0;
    adv_tog_o      = 1'b0;

    unique case (state_q)
      StIdle: begin
        // Slices only request for a matching, enabled endpoint
        if (|start_i) begin
          state_d    = StWaitData;
          xact_start = 1'b1;
        end
      end

      StWaitData: begin
        timeout_d = timeout_q - 1'b1;
        if (rx_pkt_start_i) begin
          state_d = StInData;
        end else if (timeout_q == '0) begin
          // Host never sent its data packet
          state_d = StIdle;
        end
      end

      StInData: begin
        if (bad_tog && !ep_stall) begin
          // Our last ACK was probably lost so ACK again and drop the data
          state_d        = StIdle;
          rollback_o     = 1'b1;
          tx_pkt_start_o = 1'b1;
          tx_pid_o       = UsbPidAck;
        end else if (tok.bad_end) begin
          // No reply at all on a broken packet
          state_d    = StIdle;
          rollback_o = 1'b1;
        end else if (tok.data_end) begin
          state_d = StDataEnd;
        end
      end

      StDataEnd: begin
        state_d        = StIdle;
        tx_pkt_start_o = 1'b1;
        if (setup_q) begin
          // SETUP must be taken or dropped silently
          if (nak_q || ep_full) begin
            tx_pkt_start_o = 1'b0;
            rollback_o     = 1'b1;
          end else begin
            tx_pid_o  = UsbPidAck;
            acked_o   = 1'b1;
            adv_tog_o = 1'b1;
          end
        end else if (ep_stall) begin
          tx_pid_o = UsbPidStall;
        end else if (nak_q || ep_full) begin
          tx_pid_o   = UsbPidNak;
          rollback_o = 1'b1;
        end else begin
          tx_pid_o  = UsbPidAck;
          acked_o   = 1'b1;
          adv_tog_o = 1'b1;
        end
      end

      default: state_d = StIdle;
    endcase
  end

  ////////////////////
  // State registers
  ////////////////////

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= StIdle;
      timeout_q <= AckTimeoutCntW'(AckTimeoutCnt);
    end else begin
      state_q   <= link_reset_i ? StIdle : state_d;
      timeout_q <= timeout_d;
    end
  end

  // Latch endpoint and token type when a transaction starts
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      newpkt_o <= 1'b0;
      cur_ep_o <= '0;
      setup_q  <= 1'b0;
    end else begin
      newpkt_o <= xact_start;
      if (xact_start) begin
        cur_ep_o <= tok.tok_ep;
        setup_q  <= tok.tok_setup;
      end
    end
  end

  ////////////////////
  // Data put path
  ////////////////////

  // Put strobe trails the rx strobe by one cycle
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_put_o <= 1'b0;
    end else begin
      data_put_o <= (state_q == StInData) && rx_data_put_i;
    end
  end

  always_ff @(posedge clk_48mhz_i) begin
    if (rx_data_put_i) begin
      data_o <= rx_data_i;
    end
  end

  // Any byte landing in a full endpoint turns the reply into NAK
  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nak_q <= 1'b0;
    end else if ((state_q == StIdle) || (state_q == StWaitData)) begin
      nak_q <= 1'b0;
    end else if (data_put_o && ep_full) begin
      nak_q <= 1'b1;
    end
  end

  // Stops at the last buffer slot, extra bytes are lost
  assign inc_addr = data_put_o && !nak_q && (put_addr_o != LastAddr);

  always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
    if (!rst_ni) begin
      put_addr_o <= '0;
    end else if (state_q == StWaitData) begin
      put_addr_o <= '0;
    end else if (((state_q == StInData) || (state_q == StDataEnd)) && inc_addr) begin
      put_addr_o <= put_addr_o + 1'b1;
    end
  end

endmodule

// ==== verilog/usb_token_decode.sv ====
/*
 * Received packet decoder
 * Classifies each packet end and matches device address and endpoint
 */
`timescale 1ns/1ps

module usb_token_decode (
  input  logic       clk_48mhz_i,
  input  logic       rst_ni,
  input  logic [6:0] dev_addr_i,
  input  logic       rx_pkt_end_i,
  input  logic       rx_pkt_valid_i,
  input  logic [3:0] rx_pid_i,
  input  logic [6:0] rx_addr_i,
  input  logic [3:0] rx_endp_i,
  usb_out_tok_if.decoder tok
);
  import usb_out_pkg::*;

  usb_pid_u pid_u;
  logic     good_end;
  logic     ep_in_hw;
  logic     addr_hit;
  logic     tok_hit;
  logic     is_data;

  // Same PID nibble seen as code and as fields
  assign pid_u = rx_pid_i;

  ////////////////////
  // Packet class
  ////////////////////

  // Packet finished with good CRC
  assign good_end = rx_pkt_end_i && rx_pkt_valid_i;

  // DATA2 and MDATA never reach a full-speed device
  assign is_data = (pid_u.pid == UsbPidData0) || (pid_u.pid == UsbPidData1);

  ////////////////////
  // Token match
  ////////////////////

  // Endpoint numbers past the last slice are ignored
  assign ep_in_hw = rx_endp_i < 4'(NumOutEps);
  assign addr_hit = rx_addr_i == dev_addr_i;

  assign tok_hit = good_end &&
                   (pid_u.f.pid_type == UsbPidTypeToken) &&
                   addr_hit &&
                   ep_in_hw;

  assign tok.tok_out   = tok_hit && (pid_u.pid == UsbPidOut);
  assign tok.tok_setup = tok_hit && (pid_u.pid == UsbPidSetup);

  // Only meaningful together with a token strobe
  assign tok.tok_ep = rx_endp_i[OutEpW-1:0];

  ////////////////////
  // Data and errors
  ////////////////////

  assign tok.data_end = good_end && is_data;

  // Toggle sits in the top PID bit
  assign tok.data_tog = pid_u.f.tog;

  // Bad CRC, or a good packet that carries no data
  assign tok.bad_end = rx_pkt_end_i && (!rx_pkt_valid_i || !is_data);

endmodule
